//--- source/dmm_defines.svh
// register map, mode codes and field widths for the meter core
// spi frame layout and sequencer depth
`ifndef DMM_DEFINES_SVH
`define DMM_DEFINES_SVH

////////////////////////////////////////
// field widths
`define DMM_DATA_W          32    // register word
`define DMM_ADDR_W          7     // register address
`define DMM_COUNT_W         24    // clk counts, precharge and aperture
`define DMM_ENTRY_W         6     // azmux 4 + pc_sw 2
`define DMM_IDX_W           2     // sample index
`define DMM_MODE_W          3

`define DMM_SPI_FRAME_BITS  40    // wr flag + addr + data
`define DMM_SEQ_ENTRIES     4

////////////////////////////////////////
// register addresses
`define DMM_REG_SPI_MUX     7'h08
`define DMM_REG_4094        7'h09
`define DMM_REG_MODE        7'h0C
`define DMM_REG_DIRECT      7'h0D
`define DMM_REG_SEQ_MODE    7'h0E
`define DMM_REG_STATUS      7'h0F   // read only
`define DMM_REG_PRECHARGE   7'h10
`define DMM_REG_SEQ_N       7'h11   // entries minus one
`define DMM_REG_SEQ0        7'h12
`define DMM_REG_SEQ1        7'h13
`define DMM_REG_SEQ2        7'h14
`define DMM_REG_SEQ3        7'h15
`define DMM_REG_APERTURE    7'h16

// mode codes, pin bank source
`define DMM_MODE_DIRECT     3'd0
`define DMM_MODE_SEQ_MOCK   3'd6

`define DMM_STATUS_MAGIC    8'hAA   // low byte of status

`endif

//--- source/dmm_pkg.sv
// shared types for the meter core
// register words, counts, sequence fields
// front-end pin bank and sequencer settings structs
// state enums for the sequencer and the spi slave
`default_nettype none

`include "dmm_defines.svh"

package dmm_pkg;

  typedef logic [`DMM_DATA_W-1:0]  reg_word_t;
  typedef logic [`DMM_ADDR_W-1:0]  reg_addr_t;
  typedef logic [`DMM_COUNT_W-1:0] clk_count_t;
  typedef logic [`DMM_ENTRY_W-1:0] seq_entry_t;  // {azmux, pc_sw}
  typedef logic [`DMM_IDX_W-1:0]   seq_idx_t;
  typedef logic [`DMM_MODE_W-1:0]  mode_t;

  // front-end pins, msb first, leds land on bits 3:0
  typedef struct packed {
    logic       spi_interrupt;  // 23
    logic       cmpr_latch;     // 22
    logic [3:0] adc_refmux;     // 21:18
    logic [3:0] azmux;          // 17:14
    logic [1:0] pc_sw;          // 13:12
    logic [7:0] monitor;        // 11:4
    logic [3:0] leds;           // 3:0
  } pin_bank_t;

  typedef struct packed {
    clk_count_t                             precharge;
    seq_idx_t                               last;   // wrap point
    seq_entry_t [`DMM_SEQ_ENTRIES-1:0]      entry;
  } seq_cfg_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_APPLY,       // put entry on azmux / pc_sw
    SEQ_PRECHARGE,
    SEQ_MEASURE      // adc released, wait measure valid
  } seq_state_t;

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_ADDR,
    SPI_DATA
  } spi_state_t;

endpackage

`default_nettype wire

//--- source/spi_frame_rx.sv
// spi slave, mode 0, oversampled in the clk domain
// 40 bit frame: wr flag, 7 bit address, 32 bit data
// address strobe after the header, write strobe at frame end
// read word shifted out on sdo on falling sck
`default_nettype none

`include "dmm_defines.svh"

module spi_frame_rx import dmm_pkg::*; (
  input  logic      clk,
  input  logic      rst_i,
  input  logic      sck_i,
  input  logic      ss_i,
  input  logic      sdi_i,
  input  reg_word_t rd_data_i,
  output logic      sdo_o,
  output logic      addr_valid_o,
  output reg_addr_t addr_o,
  output logic      wr_stb_o,
  output reg_word_t wr_data_o
);

  localparam int unsigned CNT_W = $clog2(`DMM_SPI_FRAME_BITS + 1);
  localparam logic [CNT_W-1:0] HDR_LAST   = CNT_W'(`DMM_ADDR_W);        // 8th bit
  localparam logic [CNT_W-1:0] FRAME_LAST = CNT_W'(`DMM_SPI_FRAME_BITS - 1);
  localparam logic [CNT_W-1:0] FRAME_END  = CNT_W'(`DMM_SPI_FRAME_BITS);

  logic [2:0]       sck_q;   // 2 sync + 1 edge detect
  logic [1:0]       ss_q;
  logic [1:0]       sdi_q;
  spi_state_t       state_q;
  logic [CNT_W-1:0] bit_cnt_q;
  reg_word_t        rx_q;
  reg_word_t        rx_nxt;
  reg_word_t        tx_q;
  logic             wr_q;     // frame is a write
  logic             load_q;   // rd_data valid now
  logic             sck_rise;
  logic             sck_fall;
  logic             hdr_done;
  logic             frame_done;

  assign sck_rise   = sck_q[1] & ~sck_q[2];
  assign sck_fall   = ~sck_q[1] & sck_q[2];
  assign rx_nxt     = {rx_q[`DMM_DATA_W-2:0], sdi_q[1]};
  assign hdr_done   = (state_q == SPI_ADDR) && sck_rise && (bit_cnt_q == HDR_LAST);
  assign frame_done = (state_q == SPI_DATA) && sck_rise && (bit_cnt_q == FRAME_LAST);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sck_q <= '0;
      ss_q  <= '1;   // deselected
      sdi_q <= '0;
    end else begin
      sck_q <= {sck_q[1:0], sck_i};
      ss_q  <= {ss_q[0], ss_i};
      sdi_q <= {sdi_q[0], sdi_i};
    end
  end

  ////////////////////////////////////////
  // frame control
  always_ff @(posedge clk) begin
    if (rst_i || ss_q[1]) begin   // ss high aborts, no write
      state_q      <= SPI_IDLE;
      bit_cnt_q    <= '0;
      addr_valid_o <= 1'b0;
      wr_stb_o     <= 1'b0;
      load_q       <= 1'b0;
      sdo_o        <= 1'b0;
    end else begin
      addr_valid_o <= hdr_done;
      wr_stb_o     <= frame_done && wr_q;
      load_q       <= addr_valid_o;   // reg_bank answers one clk later
      if (state_q == SPI_IDLE) state_q <= SPI_ADDR;
      if (hdr_done) state_q <= SPI_DATA;
      if (sck_rise && bit_cnt_q != FRAME_END) bit_cnt_q <= bit_cnt_q + 1'b1;
      if (sck_fall && state_q == SPI_DATA) begin
        sdo_o <= (bit_cnt_q == FRAME_END) ? 1'b0 : tx_q[`DMM_DATA_W-1];
      end
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (sck_rise) rx_q <= rx_nxt;
    if (hdr_done) begin
      addr_o <= rx_nxt[`DMM_ADDR_W-1:0];
      wr_q   <= rx_nxt[`DMM_ADDR_W];
    end
    if (frame_done) wr_data_o <= rx_nxt;
    if (load_q) begin
      tx_q <= rd_data_i;
    end else if (sck_fall && state_q == SPI_DATA) begin
      tx_q <= {tx_q[`DMM_DATA_W-2:0], 1'b0};   // msb first
    end
  end

endmodule

`default_nettype wire

//--- source/reg_bank.sv
// register bank behind the spi slave
// write decode, registered read mux, status word
// config fields fanned out to sequencer, adc mock and pin mux
`default_nettype none

`include "dmm_defines.svh"

module reg_bank import dmm_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       addr_valid_i,
  input  logic       wr_stb_i,
  input  reg_addr_t  addr_i,
  input  reg_word_t  wr_data_i,
  input  logic [3:0] hw_flags_i,
  input  seq_idx_t   sample_idx_last_i,
  output reg_word_t  rd_data_o,
  output mode_t      mode_o,
  output pin_bank_t  direct_o,
  output logic [3:0] spi_mux_o,
  output logic       oe_4094_o,
  output seq_cfg_t   seq_cfg_o,
  output clk_count_t aperture_o
);

  reg_word_t spi_mux_q;
  reg_word_t r4094_q;
  reg_word_t mode_q;
  reg_word_t direct_q;
  reg_word_t seq_mode_q;    // only reported back in status
  reg_word_t precharge_q;
  reg_word_t seq_n_q;
  reg_word_t aperture_q;
  reg_word_t seq_q [`DMM_SEQ_ENTRIES];
  reg_word_t status_w;
  reg_word_t rd_w;

  ////////////////////////////////////////
  // write decode
  always_ff @(posedge clk) begin
    if (rst_i) begin
      spi_mux_q   <= '0;
      r4094_q     <= '0;   // 4094 outputs off at power up
      mode_q      <= '0;   // direct mode
      direct_q    <= '0;
      seq_mode_q  <= '0;
      precharge_q <= '0;
      seq_n_q     <= '0;
      aperture_q  <= '0;
      for (int i = 0; i < `DMM_SEQ_ENTRIES; i++) seq_q[i] <= '0;
    end else if (wr_stb_i) begin
      case (addr_i)
        `DMM_REG_SPI_MUX:   spi_mux_q   <= wr_data_i;
        `DMM_REG_4094:      r4094_q     <= wr_data_i;
        `DMM_REG_MODE:      mode_q      <= wr_data_i;
        `DMM_REG_DIRECT:    direct_q    <= wr_data_i;
        `DMM_REG_SEQ_MODE:  seq_mode_q  <= wr_data_i;
        `DMM_REG_PRECHARGE: precharge_q <= wr_data_i;
        `DMM_REG_SEQ_N:     seq_n_q     <= wr_data_i;
        `DMM_REG_SEQ0:      seq_q[0]    <= wr_data_i;
        `DMM_REG_SEQ1:      seq_q[1]    <= wr_data_i;
        `DMM_REG_SEQ2:      seq_q[2]    <= wr_data_i;
        `DMM_REG_SEQ3:      seq_q[3]    <= wr_data_i;
        `DMM_REG_APERTURE:  aperture_q  <= wr_data_i;
        default: ;   // status and holes are read only
      endcase
    end
  end

  // bytes msb..lsb: seq mode, seq_n + last idx, spi_mux + flags, magic
  assign status_w = {4'h0, seq_mode_q[3:0],
                     2'b00, seq_n_q[`DMM_IDX_W-1:0], 2'b00, sample_idx_last_i,
                     spi_mux_q[3:0], hw_flags_i,
                     `DMM_STATUS_MAGIC};

  always_comb begin
    case (addr_i)
      `DMM_REG_SPI_MUX:   rd_w = spi_mux_q;
      `DMM_REG_4094:      rd_w = r4094_q;
      `DMM_REG_MODE:      rd_w = mode_q;
      `DMM_REG_DIRECT:    rd_w = direct_q;
      `DMM_REG_SEQ_MODE:  rd_w = seq_mode_q;
      `DMM_REG_STATUS:    rd_w = status_w;
      `DMM_REG_PRECHARGE: rd_w = precharge_q;
      `DMM_REG_SEQ_N:     rd_w = seq_n_q;
      `DMM_REG_SEQ0:      rd_w = seq_q[0];
      `DMM_REG_SEQ1:      rd_w = seq_q[1];
      `DMM_REG_SEQ2:      rd_w = seq_q[2];
      `DMM_REG_SEQ3:      rd_w = seq_q[3];
      `DMM_REG_APERTURE:  rd_w = aperture_q;
      default:            rd_w = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (addr_valid_i) rd_data_o <= rd_w;   // snapshot for the data phase
  end

  ////////////////////////////////////////
  // field outputs
  assign mode_o     = mode_q[`DMM_MODE_W-1:0];
  assign direct_o   = pin_bank_t'(direct_q[$bits(pin_bank_t)-1:0]);
  assign spi_mux_o  = spi_mux_q[3:0];
  assign oe_4094_o  = r4094_q[0];
  assign aperture_o = aperture_q[`DMM_COUNT_W-1:0];

  always_comb begin
    seq_cfg_o.precharge = precharge_q[`DMM_COUNT_W-1:0];
    seq_cfg_o.last      = seq_n_q[`DMM_IDX_W-1:0];
    for (int i = 0; i < `DMM_SEQ_ENTRIES; i++) begin
      seq_cfg_o.entry[i] = seq_q[i][`DMM_ENTRY_W-1:0];
    end
  end

endmodule

`default_nettype wire

//--- source/seq_acq.sv
// sequence acquisition controller
// steps azmux / pc_sw through the programmed entries
// precharge delay, then adc released until measure valid
// leds and monitor views of the current step
`default_nettype none

module seq_acq import dmm_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       trig_i,          // low level holds the sequencer in reset
  input  seq_cfg_t   cfg_i,
  input  logic       measure_valid_i,
  output logic [3:0] azmux_o,
  output logic [1:0] pc_sw_o,
  output logic       adc_reset_no,
  output seq_idx_t   sample_idx_last_o,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o
);

  seq_state_t state_q;
  seq_idx_t   idx_q;
  clk_count_t cnt_q;
  clk_count_t cnt_nxt;
  seq_entry_t entry;

  assign cnt_nxt = cnt_q + 1'b1;
  assign entry   = cfg_i.entry[idx_q];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q           <= SEQ_IDLE;
      idx_q             <= '0;
      cnt_q             <= '0;
      azmux_o           <= '0;
      pc_sw_o           <= '0;
      adc_reset_no      <= 1'b0;
      sample_idx_last_o <= '0;
    end else if (!trig_i) begin
      // parked on entry 0, adc held in reset
      state_q              <= SEQ_IDLE;
      idx_q                <= '0;
      cnt_q                <= '0;
      {azmux_o, pc_sw_o}   <= cfg_i.entry[0];
      adc_reset_no         <= 1'b0;
    end else begin
      case (state_q)
        SEQ_IDLE: state_q <= SEQ_APPLY;

        SEQ_APPLY: begin
          {azmux_o, pc_sw_o} <= entry;
          cnt_q              <= '0;
          state_q            <= SEQ_PRECHARGE;
        end

        SEQ_PRECHARGE: begin
          cnt_q <= cnt_nxt;
          if (cnt_nxt >= cfg_i.precharge) begin
            adc_reset_no <= 1'b1;   // start aperture
            state_q      <= SEQ_MEASURE;
          end
        end

        SEQ_MEASURE: begin
          if (measure_valid_i) begin
            sample_idx_last_o <= idx_q;   // completed sample
            adc_reset_no      <= 1'b0;
            idx_q             <= (idx_q == cfg_i.last) ? '0 : idx_q + 1'b1;
            state_q           <= SEQ_APPLY;
          end
        end

        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // status views
  assign leds_o    = 4'b0001 << idx_q;   // one-hot step
  assign monitor_o = {4'b0000, idx_q, measure_valid_i, adc_reset_no};

endmodule

`default_nettype wire

//--- source/adc_mock.sv
// stand-in for the adc
// counts the aperture while reset is released, one measure valid pulse
`default_nettype none

module adc_mock import dmm_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       adc_reset_ni,
  input  clk_count_t aperture_i,
  output logic       measure_valid_o
);

  clk_count_t cnt_q;
  clk_count_t cnt_nxt;
  logic       done_q;   // holds after the pulse until reset again

  assign cnt_nxt = cnt_q + 1'b1;

  always_ff @(posedge clk) begin
    if (rst_i || !adc_reset_ni) begin
      cnt_q           <= '0;
      done_q          <= 1'b0;
      measure_valid_o <= 1'b0;
    end else begin
      measure_valid_o <= 1'b0;
      if (!done_q) begin
        cnt_q <= cnt_nxt;
        if (cnt_nxt >= aperture_i) begin
          measure_valid_o <= 1'b1;
          done_q          <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/pin_mux.sv
// front-end pin bank source select by mode
// shared spi bus routing onto the peripheral chip selects
`default_nettype none

`include "dmm_defines.svh"

module pin_mux import dmm_pkg::*; (
  input  mode_t      mode_i,
  input  pin_bank_t  direct_i,
  input  pin_bank_t  seq_pins_i,
  input  logic [3:0] spi_mux_i,
  input  logic       oe_4094_i,
  input  logic       sck_i,
  input  logic       sdi_i,
  input  logic       spi_cs2_i,
  output pin_bank_t  pins_o,
  output logic       spi_glb_clk_o,
  output logic       spi_glb_mosi_o,
  output logic       spi_4094_strobe_o,
  output logic       spi_4094_oe_o,
  output logic       spi_dac_ss_o,
  output logic       spi_iso_dac_cs_o,
  output logic       spi_iso_dac_cs2_o
);

  logic spi_idle;

  always_comb begin
    case (mode_i)
      `DMM_MODE_DIRECT:   pins_o = direct_i;     // register drives every pin
      `DMM_MODE_SEQ_MOCK: pins_o = seq_pins_i;   // sequencer + mocked adc
      default:            pins_o = '0;
    endcase
  end

  ////////////////////////////////////////
  // spi routing
  assign spi_idle = (spi_mux_i == 4'b0000);

  assign spi_glb_clk_o     = spi_idle ? 1'b1 : sck_i;   // park hi
  assign spi_glb_mosi_o    = spi_idle ? 1'b1 : sdi_i;   // park hi

  // 4094 strobe active hi, park lo
  assign spi_4094_strobe_o = (spi_mux_i == 4'b0001) ? ~spi_cs2_i : 1'b0;
  // dac selects active lo, park hi
  assign spi_dac_ss_o      = (spi_mux_i == 4'b0010) ? spi_cs2_i : 1'b1;
  assign spi_iso_dac_cs_o  = (spi_mux_i == 4'b0100) ? spi_cs2_i : 1'b1;
  assign spi_iso_dac_cs2_o = (spi_mux_i == 4'b1000) ? spi_cs2_i : 1'b1;

  assign spi_4094_oe_o     = oe_4094_i;

endmodule

`default_nettype wire

//--- source/dmm_top.sv
// meter core top level
// spi slave, register bank, sequencer, adc mock, pin mux
// sequencer pin bank assembly and pin split
`default_nettype none

module dmm_top import dmm_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  // spi slave pins
  input  logic       sck_i,
  input  logic       ss_i,
  input  logic       sdi_i,
  output logic       sdo_o,
  input  logic       spi_cs2_i,
  input  logic [3:0] hw_flags_i,
  input  logic       trig_sa_i,
  // front-end pin bank
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic [3:0] adc_refmux_o,
  output logic       adc_cmpr_latch_o,
  output logic       spi_interrupt_o,
  // peripheral spi bus
  output logic       spi_glb_clk_o,
  output logic       spi_glb_mosi_o,
  output logic       spi_4094_strobe_o,
  output logic       spi_4094_oe_o,
  output logic       spi_dac_ss_o,
  output logic       spi_iso_dac_cs_o,
  output logic       spi_iso_dac_cs2_o
);

  reg_word_t  rd_data;
  reg_word_t  wr_data;
  reg_addr_t  addr;
  logic       addr_valid;
  logic       wr_stb;
  mode_t      mode;
  pin_bank_t  direct;
  pin_bank_t  seq_pins;
  pin_bank_t  pins;
  logic [3:0] spi_mux;
  logic       oe_4094;
  seq_cfg_t   seq_cfg;
  clk_count_t aperture;
  seq_idx_t   sample_idx_last;
  logic       adc_reset_n;
  logic       measure_valid;

  spi_frame_rx u_spi (
    .clk, .rst_i, .sck_i, .ss_i, .sdi_i,
    .rd_data_i    (rd_data),
    .sdo_o,
    .addr_valid_o (addr_valid),
    .addr_o       (addr),
    .wr_stb_o     (wr_stb),
    .wr_data_o    (wr_data)
  );

  reg_bank u_regs (
    .clk, .rst_i,
    .addr_valid_i (addr_valid), .wr_stb_i (wr_stb),
    .addr_i (addr), .wr_data_i (wr_data),
    .hw_flags_i, .sample_idx_last_i (sample_idx_last),
    .rd_data_o (rd_data), .mode_o (mode), .direct_o (direct),
    .spi_mux_o (spi_mux), .oe_4094_o (oe_4094),
    .seq_cfg_o (seq_cfg), .aperture_o (aperture)
  );

  // mode 6 bank, no refmux / latch / interrupt without the real adc
  assign seq_pins.spi_interrupt = 1'b0;
  assign seq_pins.cmpr_latch    = 1'b0;
  assign seq_pins.adc_refmux    = 4'b0000;

  seq_acq u_seq (
    .clk, .rst_i,
    .trig_i (trig_sa_i), .cfg_i (seq_cfg), .measure_valid_i (measure_valid),
    .azmux_o (seq_pins.azmux), .pc_sw_o (seq_pins.pc_sw),
    .adc_reset_no (adc_reset_n), .sample_idx_last_o (sample_idx_last),
    .leds_o (seq_pins.leds), .monitor_o (seq_pins.monitor)
  );

  adc_mock u_adc (
    .clk, .rst_i,
    .adc_reset_ni (adc_reset_n), .aperture_i (aperture),
    .measure_valid_o (measure_valid)
  );

  pin_mux u_pins (
    .mode_i (mode), .direct_i (direct), .seq_pins_i (seq_pins),
    .spi_mux_i (spi_mux), .oe_4094_i (oe_4094),
    .sck_i, .sdi_i, .spi_cs2_i,
    .pins_o (pins),
    .spi_glb_clk_o, .spi_glb_mosi_o, .spi_4094_strobe_o, .spi_4094_oe_o,
    .spi_dac_ss_o, .spi_iso_dac_cs_o, .spi_iso_dac_cs2_o
  );

  assign {spi_interrupt_o, adc_cmpr_latch_o, adc_refmux_o, azmux_o,
          pc_sw_o, monitor_o, leds_o} = pins;

endmodule

`default_nettype wire

//--- verif/tb_dmm_top.sv
// testbench for the meter core top level
// spi register access, status word, direct mode, spi routing
// sequencer stepping in mode 6 and masking of other modes
`default_nettype none

`include "dmm_defines.svh"

module tb_dmm_top import dmm_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    reg_addr_t addr;
    reg_word_t wdata;
    reg_word_t exp_val;   // expected read back
  } reg_case_t;

  logic       clk, rst_i, sck_i, ss_i, sdi_i, sdo_o, spi_cs2_i, trig_sa_i;
  logic [3:0] hw_flags_i, leds_o, azmux_o, adc_refmux_o;
  logic [7:0] monitor_o;
  logic [1:0] pc_sw_o;
  logic       adc_cmpr_latch_o, spi_interrupt_o;
  logic       spi_glb_clk_o, spi_glb_mosi_o, spi_4094_strobe_o, spi_4094_oe_o;
  logic       spi_dac_ss_o, spi_iso_dac_cs_o, spi_iso_dac_cs2_o;

  reg_case_t  cases[$];
  reg_addr_t  rand_regs[7] = '{`DMM_REG_DIRECT, `DMM_REG_PRECHARGE, `DMM_REG_SEQ0,
                               `DMM_REG_SEQ1, `DMM_REG_SEQ2, `DMM_REG_SEQ3,
                               `DMM_REG_APERTURE};

  dmm_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  ////////////////////////////////////////
  // helpers
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #10;   // drive point after the edge
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      stop_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // bytes msb..lsb: seq mode, seq_n + last idx, spi_mux + flags, magic
  function automatic reg_word_t status_word(input logic [3:0] seq_mode, input logic [1:0] seq_n,
                                            input logic [1:0] idx_last, input logic [3:0] mux,
                                            input logic [3:0] flags);
    return {4'h0, seq_mode, 2'b00, seq_n, 2'b00, idx_last, mux, flags, 8'hAA};
  endfunction

  // bank layout from bit 0: leds, monitor, pc_sw, azmux, refmux, latch, interrupt
  task automatic check_pins(input logic [23:0] w);
    check_eq("leds_o", 32'(leds_o), 32'(w[3:0]));
    check_eq("monitor_o", 32'(monitor_o), 32'(w[11:4]));
    check_eq("pc_sw_o", 32'(pc_sw_o), 32'(w[13:12]));
    check_eq("azmux_o", 32'(azmux_o), 32'(w[17:14]));
    check_eq("adc_refmux_o", 32'(adc_refmux_o), 32'(w[21:18]));
    check_eq("adc_cmpr_latch_o", 32'(adc_cmpr_latch_o), 32'(w[22]));
    check_eq("spi_interrupt_o", 32'(spi_interrupt_o), 32'(w[23]));
  endtask

  // parked levels first, then the one select picked by spi_mux
  task automatic check_route(input logic [3:0] mux);
    logic exp_strobe;
    logic exp_dac;
    logic exp_iso;
    logic exp_iso2;
    exp_strobe = 1'b0;   // strobe parks lo
    exp_dac    = 1'b1;   // dac selects park hi
    exp_iso    = 1'b1;
    exp_iso2   = 1'b1;
    case (mux)
      4'h1: exp_strobe = !spi_cs2_i;   // inverted cs2
      4'h2: exp_dac    = spi_cs2_i;
      4'h4: exp_iso    = spi_cs2_i;
      4'h8: exp_iso2   = spi_cs2_i;
      default: ;
    endcase
    check_eq("spi_glb_clk_o", 32'(spi_glb_clk_o), (mux == 4'h0) ? 32'h1 : 32'(sck_i));
    check_eq("spi_glb_mosi_o", 32'(spi_glb_mosi_o), (mux == 4'h0) ? 32'h1 : 32'(sdi_i));
    check_eq("spi_4094_strobe_o", 32'(spi_4094_strobe_o), 32'(exp_strobe));
    check_eq("spi_dac_ss_o", 32'(spi_dac_ss_o), 32'(exp_dac));
    check_eq("spi_iso_dac_cs_o", 32'(spi_iso_dac_cs_o), 32'(exp_iso));
    check_eq("spi_iso_dac_cs2_o", 32'(spi_iso_dac_cs2_o), 32'(exp_iso2));
  endtask

  ////////////////////////////////////////
  // spi master, mode 0, 4 clk per sck phase
  task automatic spi_xfer(input logic wr, input reg_addr_t a, input reg_word_t d,
                          output reg_word_t q);
    logic [39:0] frame;
    frame = {wr, a, d};
    q     = '0;
    ss_i  = 1'b0;
    step(4);
    for (int i = 39; i >= 0; i--) begin
      sdi_i = frame[i];
      step(4);
      if (i < 32) q = {q[30:0], sdo_o};   // read bits, sampled before the rise
      sck_i = 1'b1;
      step(4);
      sck_i = 1'b0;
    end
    step(4);
    ss_i = 1'b1;
    step(4);   // write has landed by now
  endtask

  task automatic spi_write(input reg_addr_t a, input reg_word_t d);
    reg_word_t unused;
    spi_xfer(1'b1, a, d, unused);
  endtask

  task automatic spi_read(input reg_addr_t a, output reg_word_t q);
    spi_xfer(1'b0, a, '0, q);
  endtask

  // monitor bit 0 is the adc reset released flag, bit 1 the measure valid pulse
  task automatic wait_monitor(input int b, input logic level, input string what);
    int n;
    n = 0;
    while (monitor_o[b] !== level && n < 200) begin
      step(1);
      n++;
    end
    if (monitor_o[b] !== level) stop_run($sformatf("timeout waiting for %s", what));
  endtask

  task automatic add_case(input reg_addr_t a, input reg_word_t w, input reg_word_t e);
    cases.push_back('{a, w, e});
  endtask

  ////////////////////////////////////////
  // stimulus
  initial begin
    reg_word_t  rd;
    reg_word_t  ent[4];
    logic [1:0] idx;
    logic [1:0] last_done;
    void'($urandom(10319));
    rst_i      = 1'b1;
    sck_i      = 1'b0;
    ss_i       = 1'b1;
    sdi_i      = 1'b0;
    spi_cs2_i  = 1'b1;
    trig_sa_i  = 1'b0;
    hw_flags_i = 4'h5;
    step(10);
    rst_i = 1'b0;
    step(2);

    // reset state
    check_pins(24'h0);
    check_route(4'h0);
    check_eq("sdo_o", 32'(sdo_o), 32'h0);
    spi_read(`DMM_REG_STATUS, rd);
    check_eq("status", rd, status_word(4'h0, 2'd0, 2'd0, 4'h0, hw_flags_i));

    // register table, write then read back
    add_case(`DMM_REG_SPI_MUX, 32'h0000_0004, 32'h0000_0004);
    add_case(`DMM_REG_4094, 32'h0000_0001, 32'h0000_0001);
    add_case(`DMM_REG_MODE, 32'h0000_0003, 32'h0000_0003);   // pins masked meanwhile
    add_case(`DMM_REG_SEQ_MODE, 32'h0000_0009, 32'h0000_0009);
    add_case(`DMM_REG_SEQ_N, 32'h0000_0002, 32'h0000_0002);
    foreach (rand_regs[k]) begin
      rd = $urandom();
      add_case(rand_regs[k], rd, rd);
    end
    add_case(`DMM_REG_STATUS, 32'hFFFF_FFFF, status_word(4'h9, 2'd2, 2'd0, 4'h4, hw_flags_i));
    add_case(7'h40, $urandom(), 32'h0);   // hole in the map
    foreach (cases[k]) begin
      spi_write(cases[k].addr, cases[k].wdata);
      spi_read(cases[k].addr, rd);
      check_eq($sformatf("register 0x%02h", cases[k].addr), rd, cases[k].exp_val);
    end

    // direct mode
    spi_write(`DMM_REG_MODE, 32'd0);
    rd = $urandom();
    spi_write(`DMM_REG_DIRECT, rd);
    check_pins(rd[23:0]);

    // spi routing, one select per mux value
    for (int k = 0; k < 4; k++) begin
      spi_write(`DMM_REG_SPI_MUX, 32'(4'b0001 << k));
      for (int c = 0; c < 2; c++) begin
        spi_cs2_i = c[0];
        sck_i     = c[0];   // glb clk mirror
        sdi_i     = ~c[0];
        step(1);
        check_route(4'b0001 << k);
      end
      sck_i = 1'b0;
    end
    check_eq("spi_4094_oe_o", 32'(spi_4094_oe_o), 32'h1);
    spi_write(`DMM_REG_4094, 32'h0);
    check_eq("spi_4094_oe_o", 32'(spi_4094_oe_o), 32'h0);

    ////////////////////////////////////////
    // sequencer, three entries, small counts
    spi_write(`DMM_REG_SEQ_N, 32'd2);
    spi_write(`DMM_REG_PRECHARGE, 32'd3);
    spi_write(`DMM_REG_APERTURE, 32'd5);
    for (int i = 0; i < 4; i++) begin
      ent[i] = $urandom();
      spi_write(7'(`DMM_REG_SEQ0 + i), ent[i]);
    end
    spi_write(`DMM_REG_MODE, 32'd6);
    check_pins({6'h0, ent[0][5:2], ent[0][1:0], 8'h00, 4'b0001});   // parked on entry 0
    trig_sa_i = 1'b1;
    idx       = 2'd0;
    last_done = 2'd0;
    for (int s = 0; s < 8; s++) begin
      wait_monitor(0, 1'b1, "adc reset release");
      check_eq("azmux_o", 32'(azmux_o), 32'(ent[idx][5:2]));
      check_eq("pc_sw_o", 32'(pc_sw_o), 32'(ent[idx][1:0]));
      check_eq("leds_o", 32'(leds_o), 32'(4'b0001 << idx));
      check_eq("monitor_o[3:2]", 32'(monitor_o[3:2]), 32'(idx));
      wait_monitor(1, 1'b1, "measure valid pulse");
      check_eq("monitor_o[0]", 32'(monitor_o[0]), 32'h1);   // still released on the pulse
      wait_monitor(0, 1'b0, "end of measurement");
      last_done = idx;
      idx       = (idx == 2'd2) ? 2'd0 : idx + 2'd1;   // wrap after last index
    end
    trig_sa_i = 1'b0;
    step(2);
    check_pins({6'h0, ent[0][5:2], ent[0][1:0], 8'h00, 4'b0001});
    spi_read(`DMM_REG_STATUS, rd);
    check_eq("status", rd, status_word(4'h9, 2'd2, last_done, 4'h8, hw_flags_i));

    // other modes blank the bank
    for (int m = 1; m < 8; m++) begin
      if (m != 6) begin
        spi_write(`DMM_REG_MODE, 32'(m));
        check_pins(24'h0);
      end
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+source
source/dmm_pkg.sv
source/spi_frame_rx.sv
source/reg_bank.sv
source/seq_acq.sv
source/adc_mock.sv
source/pin_mux.sv
source/dmm_top.sv
verif/tb_dmm_top.sv

//--- Makefile
# verilator build and run of the meter core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_dmm_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
